// File: ex_pkg.sv
`default_nettype none

package ex_pkg;

    localparam int NB_DATA  = 32;
    localparam int NB_REG   = 5;
    localparam int NB_OPC   = 6;
    localparam int NB_SHAMT = 5;

    typedef logic [NB_DATA-1:0]  data_t;
    typedef logic [NB_REG-1:0]   reg_addr_t;
    typedef logic [NB_OPC-1:0]   opcode_t;
    typedef logic [NB_OPC-1:0]   func_t;
    typedef logic [NB_SHAMT-1:0] shamt_t;
    typedef logic [1:0]          alu_class_t;
    typedef logic [1:0]          fwd_sel_t;

    // aluOp class from the control unit
    localparam alu_class_t ALU_CLASS_MEM    = 2'b00;
    localparam alu_class_t ALU_CLASS_BRANCH = 2'b01;
    localparam alu_class_t ALU_CLASS_RTYPE  = 2'b10;
    localparam alu_class_t ALU_CLASS_ITYPE  = 2'b11;

    // 01 is never produced
    localparam fwd_sel_t FWD_REG   = 2'b00;
    localparam fwd_sel_t FWD_MEMWB = 2'b10;
    localparam fwd_sel_t FWD_EXMEM = 2'b11;

    typedef enum logic [3:0] {
        OP_ADD,
        OP_SUB,
        OP_AND,
        OP_OR,
        OP_XOR,
        OP_NOR,
        OP_SLT,
        OP_SLTU,
        OP_SLL,
        OP_SRL,
        OP_SRA,
        OP_LUI
    } alu_op_e;

    // r-type function field
    localparam func_t FUNC_SLL  = 6'b000000;
    localparam func_t FUNC_SRL  = 6'b000010;
    localparam func_t FUNC_SRA  = 6'b000011;
    localparam func_t FUNC_ADD  = 6'b100000;
    localparam func_t FUNC_ADDU = 6'b100001;
    localparam func_t FUNC_SUB  = 6'b100010;
    localparam func_t FUNC_SUBU = 6'b100011;
    localparam func_t FUNC_AND  = 6'b100100;
    localparam func_t FUNC_OR   = 6'b100101;
    localparam func_t FUNC_XOR  = 6'b100110;
    localparam func_t FUNC_NOR  = 6'b100111;
    localparam func_t FUNC_SLT  = 6'b101010;
    localparam func_t FUNC_SLTU = 6'b101011;

    // i-type opcodes
    localparam opcode_t OPC_ADDI = 6'b001000;
    localparam opcode_t OPC_SLTI = 6'b001010;
    localparam opcode_t OPC_ANDI = 6'b001100;
    localparam opcode_t OPC_ORI  = 6'b001101;
    localparam opcode_t OPC_XORI = 6'b001110;
    localparam opcode_t OPC_LUI  = 6'b001111;

    // memory access width, 11 is a full word
    localparam logic [1:0] WIDTH_WORD = 2'b11;

    typedef struct packed {
        logic       mem_read;
        logic       mem_write;
        logic [1:0] width;
        logic       sign_flag;
    } mem_ctrl_t;

    typedef struct packed {
        logic mem2reg;
        logic reg_write;
    } wb_ctrl_t;

    typedef struct packed {
        reg_addr_t  rs;
        reg_addr_t  rt;
        reg_addr_t  rd;
        data_t      reg_da;
        data_t      reg_db;
        data_t      immediate;
        opcode_t    opcode;
        shamt_t     shamt;
        func_t      func;
        logic       reg_dst;
        logic       immediate_flag;
        alu_class_t alu_class;
        mem_ctrl_t  mem;
        wb_ctrl_t   wb;
    } id_ex_t;

    typedef struct packed {
        data_t     result;
        data_t     data4mem;
        reg_addr_t write_reg;
        mem_ctrl_t mem;
        wb_ctrl_t  wb;
    } ex_mem_t;

    typedef struct packed {
        logic      reg_write;
        reg_addr_t write_reg;
        data_t     value;
    } memwb_fwd_t;

    localparam ex_mem_t EX_MEM_RST = '{
        result    : '0,
        data4mem  : '0,
        write_reg : '0,
        mem       : '{mem_read: 1'b0, mem_write: 1'b0, width: WIDTH_WORD, sign_flag: 1'b0},
        wb        : '{mem2reg: 1'b0, reg_write: 1'b0}
    };

endpackage

`default_nettype wire

// File: alu_control.sv
`timescale 1ns/10ps
`default_nettype none

module alu_control (
    input  wire ex_pkg::alu_class_t i_alu_class,
    input  wire ex_pkg::func_t      i_func,
    input  wire ex_pkg::opcode_t    i_opcode,
    output ex_pkg::alu_op_e         o_alu_op
);

    always_comb begin
        o_alu_op = ex_pkg::OP_ADD;
        case (i_alu_class)
            ex_pkg::ALU_CLASS_MEM: begin
                // address calculation
                o_alu_op = ex_pkg::OP_ADD;
            end
            ex_pkg::ALU_CLASS_BRANCH: begin
                o_alu_op = ex_pkg::OP_SUB;
            end
            ex_pkg::ALU_CLASS_RTYPE: begin
                case (i_func)
                    ex_pkg::FUNC_ADD,
                    ex_pkg::FUNC_ADDU: o_alu_op = ex_pkg::OP_ADD;
                    ex_pkg::FUNC_SUB,
                    ex_pkg::FUNC_SUBU: o_alu_op = ex_pkg::OP_SUB;
                    ex_pkg::FUNC_AND:  o_alu_op = ex_pkg::OP_AND;
                    ex_pkg::FUNC_OR:   o_alu_op = ex_pkg::OP_OR;
                    ex_pkg::FUNC_XOR:  o_alu_op = ex_pkg::OP_XOR;
                    ex_pkg::FUNC_NOR:  o_alu_op = ex_pkg::OP_NOR;
                    ex_pkg::FUNC_SLT:  o_alu_op = ex_pkg::OP_SLT;
                    ex_pkg::FUNC_SLTU: o_alu_op = ex_pkg::OP_SLTU;
                    ex_pkg::FUNC_SLL:  o_alu_op = ex_pkg::OP_SLL;
                    ex_pkg::FUNC_SRL:  o_alu_op = ex_pkg::OP_SRL;
                    ex_pkg::FUNC_SRA:  o_alu_op = ex_pkg::OP_SRA;
                    default:           o_alu_op = ex_pkg::OP_ADD;
                endcase
            end
            ex_pkg::ALU_CLASS_ITYPE: begin
                case (i_opcode)
                    ex_pkg::OPC_ADDI: o_alu_op = ex_pkg::OP_ADD;
                    ex_pkg::OPC_ANDI: o_alu_op = ex_pkg::OP_AND;
                    ex_pkg::OPC_ORI:  o_alu_op = ex_pkg::OP_OR;
                    ex_pkg::OPC_XORI: o_alu_op = ex_pkg::OP_XOR;
                    ex_pkg::OPC_SLTI: o_alu_op = ex_pkg::OP_SLT;
                    ex_pkg::OPC_LUI:  o_alu_op = ex_pkg::OP_LUI;
                    default:          o_alu_op = ex_pkg::OP_ADD;
                endcase
            end
            default: begin
                o_alu_op = ex_pkg::OP_ADD;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: alu.sv
`timescale 1ns/10ps
`default_nettype none

module alu (
    input  wire ex_pkg::alu_op_e i_op,
    input  wire ex_pkg::data_t   i_data_a,
    input  wire ex_pkg::data_t   i_data_b,
    input  wire ex_pkg::shamt_t  i_shamt,
    input  wire ex_pkg::data_t   i_immediate,
    output ex_pkg::data_t        o_result
);

    logic lt_signed;
    logic lt_unsigned;

    // compare flags, zero extended into the result
    assign lt_signed   = $signed(i_data_a) < $signed(i_data_b);
    assign lt_unsigned = i_data_a < i_data_b;

    always_comb begin
        case (i_op)
            ex_pkg::OP_ADD: begin
                o_result = i_data_a + i_data_b;
            end
            ex_pkg::OP_SUB: begin
                o_result = i_data_a - i_data_b;
            end
            ex_pkg::OP_AND: begin
                o_result = i_data_a & i_data_b;
            end
            ex_pkg::OP_OR: begin
                o_result = i_data_a | i_data_b;
            end
            ex_pkg::OP_XOR: begin
                o_result = i_data_a ^ i_data_b;
            end
            ex_pkg::OP_NOR: begin
                o_result = ~(i_data_a | i_data_b);
            end
            ex_pkg::OP_SLT: begin
                o_result = {{(ex_pkg::NB_DATA-1){1'b0}}, lt_signed};
            end
            ex_pkg::OP_SLTU: begin
                o_result = {{(ex_pkg::NB_DATA-1){1'b0}}, lt_unsigned};
            end
            // shifts act on operand b
            ex_pkg::OP_SLL: begin
                o_result = i_data_b << i_shamt;
            end
            ex_pkg::OP_SRL: begin
                o_result = i_data_b >> i_shamt;
            end
            ex_pkg::OP_SRA: begin
                o_result = $signed(i_data_b) >>> i_shamt;
            end
            ex_pkg::OP_LUI: begin
                o_result = {i_immediate[15:0], 16'h0000};
            end
            default: begin
                o_result = i_data_a + i_data_b;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: forwarding_unit.sv
`timescale 1ns/10ps
`default_nettype none

module forwarding_unit (
    input  wire ex_pkg::reg_addr_t  i_rs,
    input  wire ex_pkg::reg_addr_t  i_rt,
    input  wire                     i_exmem_reg_write,
    input  wire ex_pkg::reg_addr_t  i_exmem_write_reg,
    input  wire ex_pkg::memwb_fwd_t i_memwb,
    output ex_pkg::fwd_sel_t        o_fw_a,
    output ex_pkg::fwd_sel_t        o_fw_b
);

    // newest producer wins, r0 is hardwired
    function automatic ex_pkg::fwd_sel_t fwd_select(
        input ex_pkg::reg_addr_t  src,
        input logic               exmem_wr,
        input ex_pkg::reg_addr_t  exmem_dst,
        input ex_pkg::memwb_fwd_t memwb
    );
        ex_pkg::fwd_sel_t sel;
        sel = ex_pkg::FWD_REG;
        if (src != '0) begin
            if (exmem_wr && (exmem_dst == src)) begin
                sel = ex_pkg::FWD_EXMEM;
            end else if (memwb.reg_write && (memwb.write_reg == src)) begin
                sel = ex_pkg::FWD_MEMWB;
            end
        end
        return sel;
    endfunction

    always_comb begin
        o_fw_a = fwd_select(i_rs, i_exmem_reg_write, i_exmem_write_reg, i_memwb);
        o_fw_b = fwd_select(i_rt, i_exmem_reg_write, i_exmem_write_reg, i_memwb);
    end

endmodule

`default_nettype wire

// File: instruction_execute.sv
`timescale 1ns/10ps
`default_nettype none

module instruction_execute (
    input  wire                     clk,
    input  wire                     i_rst_n,
    input  wire                     i_stall,
    input  wire                     i_halt,
    input  wire ex_pkg::id_ex_t     i_id_ex,
    input  wire ex_pkg::fwd_sel_t   i_fw_a,
    input  wire ex_pkg::fwd_sel_t   i_fw_b,
    input  wire ex_pkg::data_t      i_exmem_value,
    input  wire ex_pkg::data_t      i_memwb_value,
    output ex_pkg::ex_mem_t         o_ex_mem
);

    ex_pkg::alu_op_e   alu_op;
    ex_pkg::data_t     fwd_a;
    ex_pkg::data_t     fwd_b;
    ex_pkg::data_t     alu_b;
    ex_pkg::data_t     alu_result;
    ex_pkg::reg_addr_t write_reg;
    ex_pkg::ex_mem_t   ex_next;

    function automatic ex_pkg::data_t pick_operand(
        input ex_pkg::fwd_sel_t sel,
        input ex_pkg::data_t    reg_value,
        input ex_pkg::data_t    exmem_value,
        input ex_pkg::data_t    memwb_value
    );
        ex_pkg::data_t value;
        case (sel)
            ex_pkg::FWD_EXMEM: value = exmem_value;
            ex_pkg::FWD_MEMWB: value = memwb_value;
            default:           value = reg_value;
        endcase
        return value;
    endfunction

    alu_control u_alu_ctrl (
        .i_alu_class (i_id_ex.alu_class),
        .i_func      (i_id_ex.func),
        .i_opcode    (i_id_ex.opcode),
        .o_alu_op    (alu_op)
    );

    // operand muxes
    always_comb begin
        fwd_a = pick_operand(i_fw_a, i_id_ex.reg_da, i_exmem_value, i_memwb_value);
        fwd_b = pick_operand(i_fw_b, i_id_ex.reg_db, i_exmem_value, i_memwb_value);
        alu_b = i_id_ex.immediate_flag ? i_id_ex.immediate : fwd_b;
    end

    alu u_alu (
        .i_op        (alu_op),
        .i_data_a    (fwd_a),
        .i_data_b    (alu_b),
        .i_shamt     (i_id_ex.shamt),
        .i_immediate (i_id_ex.immediate),
        .o_result    (alu_result)
    );

    // rd for r-type, rt otherwise
    assign write_reg = i_id_ex.reg_dst ? i_id_ex.rd : i_id_ex.rt;

    always_comb begin
        ex_next.result    = alu_result;
        ex_next.data4mem  = fwd_b;
        ex_next.write_reg = write_reg;
        ex_next.mem       = i_id_ex.mem;
        ex_next.wb        = i_id_ex.wb;
        // a stalled entry becomes a bubble
        if (i_stall) begin
            ex_next.mem.mem_read  = 1'b0;
            ex_next.mem.mem_write = 1'b0;
            ex_next.wb.reg_write  = 1'b0;
        end
    end

    // EX/MEM register, halt freezes everything
    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_ex_mem <= ex_pkg::EX_MEM_RST;
        end else if (!i_halt) begin
            o_ex_mem <= ex_next;
        end
    end

    // forwarding unit only drives the three defined codes
    a_fwd_sel_legal: assert property (
        @(posedge clk) disable iff (!i_rst_n)
        (i_fw_a != 2'b01) && (i_fw_b != 2'b01)
    ) else $error("illegal forwarding select a=%b b=%b", i_fw_a, i_fw_b);

    a_mem_rw_exclusive: assert property (
        @(posedge clk) disable iff (!i_rst_n)
        !(o_ex_mem.mem.mem_read && o_ex_mem.mem.mem_write)
    ) else $error("EX/MEM carries both mem_read and mem_write");

    // halted edge leaves the register untouched
    a_halt_holds: assert property (
        @(posedge clk) disable iff (!i_rst_n)
        i_halt |=> $stable(o_ex_mem)
    ) else $error("EX/MEM changed across a halted cycle");

endmodule

`default_nettype wire

// File: execute_stage.sv
`timescale 1ns/10ps
`default_nettype none

module execute_stage (
    input  wire                     clk,
    input  wire                     i_rst_n,
    input  wire                     i_stall,
    input  wire                     i_halt,
    input  wire ex_pkg::id_ex_t     i_id_ex,
    input  wire ex_pkg::memwb_fwd_t i_mem_wb,
    output ex_pkg::ex_mem_t         o_ex_mem
);

    ex_pkg::fwd_sel_t fw_a;
    ex_pkg::fwd_sel_t fw_b;

    // EX/MEM feeds back as the newest forwarding source
    forwarding_unit u_fwd (
        .i_rs              (i_id_ex.rs),
        .i_rt              (i_id_ex.rt),
        .i_exmem_reg_write (o_ex_mem.wb.reg_write),
        .i_exmem_write_reg (o_ex_mem.write_reg),
        .i_memwb           (i_mem_wb),
        .o_fw_a            (fw_a),
        .o_fw_b            (fw_b)
    );

    instruction_execute u_ex (
        .clk           (clk),
        .i_rst_n       (i_rst_n),
        .i_stall       (i_stall),
        .i_halt        (i_halt),
        .i_id_ex       (i_id_ex),
        .i_fw_a        (fw_a),
        .i_fw_b        (fw_b),
        .i_exmem_value (o_ex_mem.result),
        .i_memwb_value (i_mem_wb.value),
        .o_ex_mem      (o_ex_mem)
    );

endmodule

`default_nettype wire

// File: tb_clock_gen.sv
`timescale 1ns/10ps
`default_nettype none

module tb_clock_gen (
    output logic o_clk,
    output logic o_rst_n
);

    // 40 ns period
    initial begin
        o_clk = 1'b0;
        forever #20 o_clk = ~o_clk;
    end

    // reset held for two cycles, released on a falling edge
    initial begin
        o_rst_n = 1'b0;
        repeat (2) @(posedge o_clk);
        @(negedge o_clk);
        o_rst_n = 1'b1;
    end

endmodule

`default_nettype wire

// File: tb_execute_stage.sv
`timescale 1ns/10ps
`default_nettype none

module tb_execute_stage;

    // cycles per test and their sum for the watchdog
    localparam int RESET_CYCLES = 2;
    localparam int RTYPE_CYCLES = 15;
    localparam int ITYPE_CYCLES = 9;
    localparam int FWD_CYCLES   = 7;
    localparam int HOLD_CYCLES  = 6;
    localparam int TOTAL_CYCLES = RESET_CYCLES + RTYPE_CYCLES + ITYPE_CYCLES
                                  + FWD_CYCLES + HOLD_CYCLES;

    logic               clk;
    logic               rst_n;
    logic               stall;
    logic               halt;
    ex_pkg::id_ex_t     id_ex;
    ex_pkg::memwb_fwd_t mem_wb;
    ex_pkg::ex_mem_t    ex_mem;
    ex_pkg::ex_mem_t    expected;
    logic [31:0]        lfsr_state;
    int                 errors;

    tb_clock_gen u_clk_gen (
        .o_clk   (clk),
        .o_rst_n (rst_n)
    );

    execute_stage u_dut (
        .clk      (clk),
        .i_rst_n  (rst_n),
        .i_stall  (stall),
        .i_halt   (halt),
        .i_id_ex  (id_ex),
        .i_mem_wb (mem_wb),
        .o_ex_mem (ex_mem)
    );

    // taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_take(input int nbits);
        logic [31:0] value;
        logic        fb;
        value = '0;
        for (int i = 0; i < nbits; i++) begin
            fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], fb};
            value = {value[30:0], fb};
        end
        return value;
    endfunction

    // random operands with the code in both func and opcode
    function automatic ex_pkg::id_ex_t make_instr(
        input ex_pkg::alu_class_t cls,
        input logic [5:0]         code,
        input ex_pkg::reg_addr_t  rs,
        input ex_pkg::reg_addr_t  rt,
        input ex_pkg::reg_addr_t  rd
    );
        ex_pkg::id_ex_t id;
        logic [15:0]    imm16;
        id = '0;
        imm16 = lfsr_take(16);
        id.rs = rs;
        id.rt = rt;
        id.rd = rd;
        id.reg_da = lfsr_take(32);
        id.reg_db = lfsr_take(32);
        id.immediate = {{16{imm16[15]}}, imm16};
        id.shamt = lfsr_take(5);
        id.func = code;
        id.opcode = code;
        id.alu_class = cls;
        id.reg_dst = (cls == ex_pkg::ALU_CLASS_RTYPE);
        id.immediate_flag = (cls == ex_pkg::ALU_CLASS_ITYPE) || (cls == ex_pkg::ALU_CLASS_MEM);
        id.mem.width = 2'b11;
        id.wb.reg_write = 1'b1;
        return id;
    endfunction

    // later match overrides so EX/MEM beats MEM/WB
    function automatic ex_pkg::data_t forward_value(
        input ex_pkg::reg_addr_t  src,
        input ex_pkg::data_t      reg_value,
        input ex_pkg::memwb_fwd_t wb,
        input ex_pkg::ex_mem_t    prev
    );
        ex_pkg::data_t value;
        value = reg_value;
        if (src != 5'd0 && wb.reg_write && wb.write_reg == src)
            value = wb.value;
        if (src != 5'd0 && prev.wb.reg_write && prev.write_reg == src)
            value = prev.result;
        return value;
    endfunction

    function automatic ex_pkg::ex_mem_t predict_ex_mem(
        input ex_pkg::id_ex_t     id,
        input ex_pkg::memwb_fwd_t wb,
        input logic               stall_in,
        input logic               halt_in,
        input ex_pkg::ex_mem_t    prev
    );
        ex_pkg::ex_mem_t nxt;
        ex_pkg::data_t   a;
        ex_pkg::data_t   b;
        ex_pkg::data_t   opb;
        ex_pkg::data_t   r;
        if (halt_in)
            return prev;
        a = forward_value(id.rs, id.reg_da, wb, prev);
        b = forward_value(id.rt, id.reg_db, wb, prev);
        opb = id.immediate_flag ? id.immediate : b;
        r = a + opb;
        if (id.alu_class == ex_pkg::ALU_CLASS_BRANCH) begin
            r = a - opb;
        end else if (id.alu_class == ex_pkg::ALU_CLASS_RTYPE) begin
            case (id.func)
                ex_pkg::FUNC_SUB, ex_pkg::FUNC_SUBU: r = a - opb;
                ex_pkg::FUNC_AND:  r = a & opb;
                ex_pkg::FUNC_OR:   r = a | opb;
                ex_pkg::FUNC_XOR:  r = a ^ opb;
                ex_pkg::FUNC_NOR:  r = ~(a | opb);
                ex_pkg::FUNC_SLT:  r = {31'b0, $signed(a) < $signed(opb)};
                ex_pkg::FUNC_SLTU: r = {31'b0, a < opb};
                ex_pkg::FUNC_SLL:  r = opb << id.shamt;
                ex_pkg::FUNC_SRL:  r = opb >> id.shamt;
                ex_pkg::FUNC_SRA:  r = $signed(opb) >>> id.shamt;
                default: ;
            endcase
        end else if (id.alu_class == ex_pkg::ALU_CLASS_ITYPE) begin
            case (id.opcode)
                ex_pkg::OPC_ANDI: r = a & opb;
                ex_pkg::OPC_ORI:  r = a | opb;
                ex_pkg::OPC_XORI: r = a ^ opb;
                ex_pkg::OPC_SLTI: r = {31'b0, $signed(a) < $signed(opb)};
                ex_pkg::OPC_LUI:  r = {id.immediate[15:0], 16'h0000};
                default: ;
            endcase
        end
        nxt.result = r;
        nxt.data4mem = b;
        nxt.write_reg = id.reg_dst ? id.rd : id.rt;
        nxt.mem = id.mem;
        nxt.wb = id.wb;
        if (stall_in) begin
            nxt.mem.mem_read = 1'b0;
            nxt.mem.mem_write = 1'b0;
            nxt.wb.reg_write = 1'b0;
        end
        return nxt;
    endfunction

    task automatic compare_field(
        input string       tag,
        input string       name,
        input logic [31:0] exp_value,
        input logic [31:0] got_value
    );
        if (exp_value !== got_value) begin
            $display("[ERROR] %s: %s expected %h got %h", tag, name, exp_value, got_value);
            errors++;
        end
    endtask

    task automatic check_ex_mem(input string tag);
        compare_field(tag, "o_ex_mem.result", expected.result, ex_mem.result);
        compare_field(tag, "o_ex_mem.data4mem", expected.data4mem, ex_mem.data4mem);
        compare_field(tag, "o_ex_mem.write_reg", expected.write_reg, ex_mem.write_reg);
        compare_field(tag, "o_ex_mem.mem", expected.mem, ex_mem.mem);
        compare_field(tag, "o_ex_mem.wb", expected.wb, ex_mem.wb);
    endtask

    // drives on a falling edge and checks on the next one
    task automatic run_cycle(
        input ex_pkg::id_ex_t     id,
        input ex_pkg::memwb_fwd_t wb,
        input logic               stall_in,
        input logic               halt_in,
        input string              tag
    );
        id_ex = id;
        mem_wb = wb;
        stall = stall_in;
        halt = halt_in;
        expected = predict_ex_mem(id, wb, stall_in, halt_in, expected);
        @(negedge clk);
        check_ex_mem(tag);
    endtask

    task automatic test_reset();
        @(negedge clk);
        expected = '0;
        expected.mem.width = 2'b11;
        check_ex_mem("during reset");
        wait (rst_n === 1'b1);
        check_ex_mem("after reset");
    endtask

    task automatic test_rtype();
        ex_pkg::func_t  funcs [13];
        ex_pkg::id_ex_t id;
        logic [3:0]     rt_low;
        logic [3:0]     rd_low;
        funcs = '{ex_pkg::FUNC_ADD, ex_pkg::FUNC_ADDU, ex_pkg::FUNC_SUB, ex_pkg::FUNC_SUBU,
                  ex_pkg::FUNC_AND, ex_pkg::FUNC_OR, ex_pkg::FUNC_XOR, ex_pkg::FUNC_NOR,
                  ex_pkg::FUNC_SLT, ex_pkg::FUNC_SLTU, ex_pkg::FUNC_SLL, ex_pkg::FUNC_SRL,
                  ex_pkg::FUNC_SRA};
        // destinations stay in r16..r31
        for (int i = 0; i < 13; i++) begin
            rt_low = lfsr_take(4);
            rd_low = lfsr_take(4);
            id = make_instr(ex_pkg::ALU_CLASS_RTYPE, funcs[i], lfsr_take(5),
                            {1'b1, rt_low}, {1'b1, rd_low});
            id.reg_dst = (i % 4 != 3);
            run_cycle(id, '0, 1'b0, 1'b0, "r-type");
        end
        // -1 against 1 splits signed from unsigned
        id = make_instr(ex_pkg::ALU_CLASS_RTYPE, ex_pkg::FUNC_SLT, 5'd1, 5'd2, 5'd3);
        id.reg_da = 32'hffff_ffff;
        id.reg_db = 32'h0000_0001;
        run_cycle(id, '0, 1'b0, 1'b0, "slt negative");
        id.func = ex_pkg::FUNC_SLTU;
        run_cycle(id, '0, 1'b0, 1'b0, "sltu negative");
    endtask

    task automatic test_itype();
        ex_pkg::opcode_t opcodes [6];
        ex_pkg::id_ex_t  id;
        opcodes = '{ex_pkg::OPC_ADDI, ex_pkg::OPC_ANDI, ex_pkg::OPC_ORI,
                    ex_pkg::OPC_XORI, ex_pkg::OPC_SLTI, ex_pkg::OPC_LUI};
        for (int i = 0; i < 6; i++) begin
            id = make_instr(ex_pkg::ALU_CLASS_ITYPE, opcodes[i], lfsr_take(5), lfsr_take(5), 5'd0);
            run_cycle(id, '0, 1'b0, 1'b0, "i-type");
        end
        // signed byte load
        id = make_instr(ex_pkg::ALU_CLASS_MEM, 6'b100000, lfsr_take(5), 5'd12, 5'd0);
        id.mem = '{mem_read: 1'b1, mem_write: 1'b0, width: 2'b00, sign_flag: 1'b1};
        id.wb.mem2reg = 1'b1;
        run_cycle(id, '0, 1'b0, 1'b0, "load");
        id = make_instr(ex_pkg::ALU_CLASS_MEM, 6'b101011, lfsr_take(5), 5'd13, 5'd0);
        id.mem.mem_write = 1'b1;
        id.wb.reg_write = 1'b0;
        run_cycle(id, '0, 1'b0, 1'b0, "store");
        id = make_instr(ex_pkg::ALU_CLASS_BRANCH, 6'b000100, lfsr_take(5), lfsr_take(5), 5'd0);
        id.wb.reg_write = 1'b0;
        run_cycle(id, '0, 1'b0, 1'b0, "branch");
    endtask

    task automatic test_forwarding();
        ex_pkg::id_ex_t     id;
        ex_pkg::memwb_fwd_t wb;
        wb = '0;
        id = make_instr(ex_pkg::ALU_CLASS_RTYPE, ex_pkg::FUNC_ADD, 5'd3, 5'd4, 5'd5);
        run_cycle(id, wb, 1'b0, 1'b0, "producer r5");
        id = make_instr(ex_pkg::ALU_CLASS_RTYPE, ex_pkg::FUNC_SUB, 5'd5, 5'd5, 5'd6);
        run_cycle(id, wb, 1'b0, 1'b0, "ex/mem forward");
        wb = '{reg_write: 1'b1, write_reg: 5'd7, value: lfsr_take(32)};
        id = make_instr(ex_pkg::ALU_CLASS_RTYPE, ex_pkg::FUNC_OR, 5'd7, 5'd7, 5'd9);
        run_cycle(id, wb, 1'b0, 1'b0, "mem/wb forward");
        // r9 in both stages
        wb = '{reg_write: 1'b1, write_reg: 5'd9, value: lfsr_take(32)};
        id = make_instr(ex_pkg::ALU_CLASS_RTYPE, ex_pkg::FUNC_XOR, 5'd9, 5'd9, 5'd10);
        run_cycle(id, wb, 1'b0, 1'b0, "ex/mem priority");
        wb.write_reg = 5'd0;
        id = make_instr(ex_pkg::ALU_CLASS_RTYPE, ex_pkg::FUNC_ADD, 5'd1, 5'd2, 5'd0);
        run_cycle(id, wb, 1'b0, 1'b0, "producer r0");
        id = make_instr(ex_pkg::ALU_CLASS_RTYPE, ex_pkg::FUNC_ADD, 5'd0, 5'd0, 5'd11);
        run_cycle(id, wb, 1'b0, 1'b0, "r0 not forwarded");
        wb = '0;
        id = make_instr(ex_pkg::ALU_CLASS_MEM, 6'b101011, 5'd0, 5'd11, 5'd0);
        id.mem.mem_write = 1'b1;
        id.wb.reg_write = 1'b0;
        run_cycle(id, wb, 1'b0, 1'b0, "store data forward");
    endtask

    task automatic test_stall_halt();
        ex_pkg::id_ex_t id;
        id = make_instr(ex_pkg::ALU_CLASS_MEM, 6'b100011, lfsr_take(5), 5'd14, 5'd0);
        id.mem.mem_read = 1'b1;
        id.wb.mem2reg = 1'b1;
        run_cycle(id, '0, 1'b1, 1'b0, "stalled load");
        id = make_instr(ex_pkg::ALU_CLASS_MEM, 6'b101011, lfsr_take(5), 5'd15, 5'd0);
        id.mem.mem_write = 1'b1;
        run_cycle(id, '0, 1'b1, 1'b0, "stalled store");
        id = make_instr(ex_pkg::ALU_CLASS_RTYPE, ex_pkg::FUNC_AND, 5'd20, 5'd21, 5'd22);
        run_cycle(id, '0, 1'b0, 1'b0, "before halt");
        id = make_instr(ex_pkg::ALU_CLASS_RTYPE, ex_pkg::FUNC_NOR, 5'd22, 5'd23, 5'd24);
        run_cycle(id, '0, 1'b0, 1'b1, "halt");
        id = make_instr(ex_pkg::ALU_CLASS_ITYPE, ex_pkg::OPC_ORI, 5'd22, 5'd25, 5'd0);
        run_cycle(id, '0, 1'b1, 1'b1, "halt over stall");
        id = make_instr(ex_pkg::ALU_CLASS_RTYPE, ex_pkg::FUNC_ADD, 5'd22, 5'd26, 5'd27);
        run_cycle(id, '0, 1'b0, 1'b0, "after halt");
    endtask

    initial begin
        stall = 1'b0;
        halt = 1'b0;
        id_ex = '0;
        mem_wb = '0;
        expected = '0;
        lfsr_state = 32'h9939;
        errors = 0;
        test_reset();
        test_rtype();
        test_itype();
        test_forwarding();
        test_stall_halt();
        $display("checks finished with %0d errors", errors);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    initial begin
        #(TOTAL_CYCLES * 40 + 400);
        $display("timeout: the tests did not finish within %0d cycles", TOTAL_CYCLES);
        $display("Simulation failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: sources.f
ex_pkg.sv
alu_control.sv
alu.sv
forwarding_unit.sv
instruction_execute.sv
execute_stage.sv
tb_clock_gen.sv
tb_execute_stage.sv
